//--- src.f
+incdir+verification
design/fetch_pkg.sv
design/fetch_predecode.sv
design/icache.sv
design/fetch_ctrl.sv
design/ifu_top.sv
verification/ifu_checker.sv
verification/ifu_tb.sv

//--- verification/ifu_tb_mem.svh
// memory image as a function of the word address.
// roughly one jal in six words, fence.i at every word index 30 mod 40, addi elsewhere.
function automatic logic [31:0] mem_word(input logic [31:0] addr);
  logic [29:0] w;
  logic [31:0] h;
  w = addr[31:2];
  h = {2'b00, w} * 32'h9e37_79b1; // spreads every address bit.
  if (w % 40 == 30)
    return fetch_pkg::fence_i_inst;
  if (h[31:16] % 6 == 0)
    return {h[19:0], 5'd1, 7'b1101111}; // jal x1.
  return {w[11:0] ^ h[31:20], w[16:12], 3'b000, h[4:0], 7'b0010011}; // addi.
endfunction

//--- verification/ifu_tb.sv
`timescale 1ns/10ps

module ifu_tb;
  `include "ifu_tb_mem.svh"

  localparam int          addr_w       = 32;
  localparam int          index_w      = 2;
  localparam logic [31:0] reset_pc     = 32'h0000_1000;
  localparam int          window_words = 32; // four times the cache, so lines get reused.
  localparam int          max_wait     = 20000;

  logic        clk;
  logic        rst;
  logic [31:0] inst_o;
  logic [31:0] pc_o;
  logic        valid_o;
  logic        ready_i;
  logic        redirect_i;
  logic [31:0] redirect_pc_i;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        await_redirect;
  int          xfer_cnt;
  int          fence_cnt;
  logic        resp_busy;
  int          resp_left;
  logic [31:0] resp_addr;
  logic        aim_fence;
  logic [31:0] fence_pc;
  logic        timed_out;
  int          failed;

  ifu_top #(
    .addr_w   (addr_w),
    .index_w  (index_w),
    .reset_pc (reset_pc)
  ) i_dut (.*);

  ifu_checker #(
    .addr_w   (addr_w),
    .index_w  (index_w),
    .reset_pc (reset_pc)
  ) i_chk (
    .clk              (clk),
    .rst              (rst),
    .inst_i           (inst_o),
    .pc_i             (pc_o),
    .valid_i          (valid_o),
    .ready_i          (ready_i),
    .redirect_i       (redirect_i),
    .redirect_pc_i    (redirect_pc_i),
    .mem_req_i        (mem_req_o),
    .mem_addr_i       (mem_addr_o),
    .await_redirect_o (await_redirect),
    .xfer_cnt_o       (xfer_cnt),
    .fence_cnt_o      (fence_cnt)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] find_fence_pc();
    logic [31:0] a;
    a = reset_pc;
    for (int i = 0; i < window_words; i++)
      if (mem_word(reset_pc + 32'(i) * 4) == fetch_pkg::fence_i_inst)
        a = reset_pc + 32'(i) * 4;
    return a;
  endfunction

  task automatic wait_count(input logic on_fence, input int goal, input string what);
    int cyc;
    cyc = 0;
    while ((on_fence ? fence_cnt : xfer_cnt) < goal && cyc < max_wait)
    begin
      @(posedge clk);
      cyc++;
    end
    if ((on_fence ? fence_cnt : xfer_cnt) < goal)
    begin
      $display("timeout: %s not reached within %0d cycles", what, max_wait);
      timed_out = 1'b1;
    end
  endtask

  // decode back-pressure and redirects after a jump.
  always @(posedge clk)
  begin
    if (rst)
    begin
      ready_i    <= 1'b0;
      redirect_i <= 1'b0;
    end
    else
    begin
      ready_i    <= ($urandom_range(3, 0) != 0);
      redirect_i <= 1'b0;
      if (await_redirect && !redirect_i && $urandom_range(1, 0) == 1)
      begin
        redirect_i    <= 1'b1;
        redirect_pc_i <= aim_fence ? fence_pc :
                         reset_pc + ($urandom_range(window_words - 1, 0) << 2);
        aim_fence     <= 1'b0;
      end
    end
  end

  // memory responder, one request outstanding.
  always @(posedge clk)
  begin
    if (rst)
    begin
      mem_rvalid_i <= 1'b0;
      resp_busy = 1'b0;
    end
    else
    begin
      mem_rvalid_i <= 1'b0;
      if (mem_req_o)
      begin
        resp_busy = 1'b1;
        resp_addr = mem_addr_o;
        resp_left = $urandom_range(6, 1);
      end
      else if (resp_busy)
      begin
        resp_left--;
        if (resp_left == 0)
        begin
          mem_rvalid_i <= 1'b1;
          mem_rdata_i  <= mem_word(resp_addr);
          resp_busy = 1'b0;
        end
      end
    end
  end

  initial
  begin
    clk           = 1'b0;
    rst           = 1'b1;
    ready_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    mem_rvalid_i  = 1'b0;
    mem_rdata_i   = '0;
    aim_fence     = 1'b0;
    timed_out     = 1'b0;
    void'($urandom(32'h5727));
    fence_pc = find_fence_pc();
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    wait_count(1'b0, 1, "first transfer");
    if (!timed_out)
      wait_count(1'b0, 300, "random traffic");
    if (!timed_out)
    begin
      aim_fence <= 1'b1; // next redirect lands on the fence.i word.
      wait_count(1'b1, fence_cnt + 1, "fence.i transfer");
    end
    if (!timed_out)
      wait_count(1'b0, xfer_cnt + 20, "refetch after fence.i");
    repeat (2) @(posedge clk);
    i_chk.report_tests(failed);
    if (!timed_out && failed == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- verification/ifu_checker.sv
`timescale 1ns/10ps

module ifu_checker #(
  parameter int                addr_w   = 32,
  parameter int                index_w  = 2,
  parameter logic [addr_w-1:0] reset_pc = 'h1000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [31:0]       inst_i,
  input  logic [addr_w-1:0] pc_i,
  input  logic              valid_i,
  input  logic              ready_i,
  input  logic              redirect_i,
  input  logic [addr_w-1:0] redirect_pc_i,
  input  logic              mem_req_i,
  input  logic [addr_w-1:0] mem_addr_i,
  output logic              await_redirect_o,
  output int                xfer_cnt_o,
  output int                fence_cnt_o
);
  import fetch_pkg::*;
  `include "ifu_tb_mem.svh"

  localparam int lines = 1 << index_w;

  string names [1:6] = '{"reset fetch", "sequential fetch", "redirect after jump",
                         "hit and refill traffic", "fence.i invalidation", "decode stall hold"};
  int                checks [1:6] = '{default: 0};
  int                errors [1:6] = '{default: 0};
  logic [addr_w-1:0] exp_pc;
  logic              after_redirect;
  logic              hold_q;
  logic [31:0]       hold_inst;
  logic [addr_w-1:0] hold_pc;
  logic [addr_w-1:0] req_log [$];
  logic              line_valid [lines]; // model of the tag store, by line number.
  logic [addr_w-1:0] line_num [lines];
  logic              stale_valid [lines]; // lines dropped by the last fence.i.
  logic [addr_w-1:0] stale_num [lines];

  task automatic check_true(input int t, input logic ok, input string what);
    checks[t]++;
    if (!ok)
    begin
      errors[t]++;
      $display("ERROR at %0t: %s", $time, what);
    end
  endtask

  task automatic check_value(input int t, input string name, input logic [31:0] got, exp);
    checks[t]++;
    if (got !== exp)
    begin
      errors[t]++;
      $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_transfer();
    logic [addr_w-1:0] num;
    logic [addr_w-1:0] base;
    logic [31:0]       exp_inst;
    int                idx;
    int                t;
    num      = pc_i >> 3; // two words per line.
    base     = {pc_i[addr_w-1:3], 3'b000};
    idx      = int'(num[index_w-1:0]);
    exp_inst = mem_word(pc_i);
    t        = (xfer_cnt_o == 0) ? 1 : (after_redirect ? 3 : 2);
    check_value(t, "pc_o", pc_i, exp_pc);
    check_value(t, "inst_o", inst_i, exp_inst);
    if (line_valid[idx] && line_num[idx] == num)
      check_true(4, req_log.size() == 0, $sformatf("bus request before a hit at pc %h", pc_i));
    else
    begin
      t = (stale_valid[idx] && stale_num[idx] == num) ? 5 : 4;
      check_true(t, req_log.size() == 2,
                 $sformatf("pc %h refilled with %0d bus requests", pc_i, req_log.size()));
      if (req_log.size() == 2)
      begin
        check_value(t, "mem_addr_o", req_log[0], base);
        check_value(t, "mem_addr_o", req_log[1], base + 4);
      end
      line_valid[idx]  = 1'b1;
      line_num[idx]    = num;
      stale_valid[idx] = 1'b0;
    end
    req_log.delete();
    if (exp_inst == fence_i_inst)
    begin
      for (int i = 0; i < lines; i++)
      begin
        stale_valid[i] = line_valid[i];
        stale_num[i]   = line_num[i];
        line_valid[i]  = 1'b0;
      end
      fence_cnt_o <= fence_cnt_o + 1;
    end
    case (exp_inst[6:0])
      op_jal, op_jalr, op_branch, op_system: await_redirect_o <= 1'b1;
      default:                               exp_pc = pc_i + 4;
    endcase
    after_redirect = 1'b0;
    xfer_cnt_o <= xfer_cnt_o + 1;
  endtask

  task automatic report_tests(output int failed);
    int total_checks;
    int total_errors;
    failed       = 0;
    total_checks = 0;
    total_errors = 0;
    for (int t = 1; t <= 6; t++)
    begin
      if (errors[t] != 0 || checks[t] == 0)
        failed++;
      total_checks += checks[t];
      total_errors += errors[t];
      $display("test %0d %s: %0d checks, %0d errors, %s", t, names[t], checks[t], errors[t],
               (errors[t] == 0 && checks[t] > 0) ? "ok" : "failed");
    end
    $display("summary: %0d transfers, %0d checks, %0d errors, %0d failing",
             xfer_cnt_o, total_checks, total_errors, failed);
  endtask

  always @(posedge clk)
  begin
    if (rst)
    begin
      await_redirect_o <= 1'b0;
      xfer_cnt_o       <= 0;
      fence_cnt_o      <= 0;
      exp_pc         = reset_pc;
      after_redirect = 1'b0;
      hold_q         = 1'b0;
      req_log.delete();
      for (int i = 0; i < lines; i++)
      begin
        line_valid[i]  = 1'b0;
        stale_valid[i] = 1'b0;
      end
    end
    else
    begin
      if (hold_q)
      begin
        check_true(6, valid_i, "valid_o dropped while decode stalled");
        check_value(6, "pc_o", pc_i, hold_pc);
        check_value(6, "inst_o", inst_i, hold_inst);
      end
      hold_q    = valid_i && !ready_i;
      hold_pc   = pc_i;
      hold_inst = inst_i;
      if (mem_req_i)
        req_log.push_back(mem_addr_i);
      if (await_redirect_o)
      begin
        check_true(3, !valid_i, "valid_o high while waiting for a redirect");
        if (redirect_i)
        begin
          exp_pc           = redirect_pc_i;
          after_redirect   = 1'b1;
          await_redirect_o <= 1'b0;
        end
      end
      else if (valid_i && ready_i)
        check_transfer();
    end
  end

endmodule

//--- design/ifu_top.sv
`timescale 1ns/10ps

module ifu_top #(
  parameter int                addr_w   = 32,
  parameter int                index_w  = 2,
  parameter logic [addr_w-1:0] reset_pc = 'h1000
) (
  input  logic              clk,
  input  logic              rst,
  output logic [31:0]       inst_o,
  output logic [addr_w-1:0] pc_o,
  output logic              valid_o,
  input  logic              ready_i,
  input  logic              redirect_i,
  input  logic [addr_w-1:0] redirect_pc_i,
  output logic              mem_req_o,
  output logic [addr_w-1:0] mem_addr_o,
  input  logic              mem_rvalid_i,
  input  logic [31:0]       mem_rdata_i
);
  import fetch_pkg::*;

  logic [addr_w-1:0] fetch_pc;
  logic              fetch_en;
  logic              invalidate;
  logic              hit;
  logic [31:0]       hit_inst;
  inst_class_e       inst_class;

  fetch_ctrl #(
    .addr_w   (addr_w),
    .reset_pc (reset_pc)
  ) i_fetch_ctrl (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .hit_i         (hit),
    .hit_inst_i    (hit_inst),
    .class_i       (inst_class),
    .fetch_pc_o    (fetch_pc),
    .fetch_en_o    (fetch_en),
    .invalidate_o  (invalidate),
    .inst_o        (inst_o),
    .pc_o          (pc_o),
    .valid_o       (valid_o),
    .ready_i       (ready_i)
  );

  icache #(
    .addr_w  (addr_w),
    .index_w (index_w)
  ) i_icache (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc_i   (fetch_pc),
    .fetch_en_i   (fetch_en),
    .invalidate_i (invalidate),
    .hit_o        (hit),
    .inst_o       (hit_inst),
    .mem_req_o    (mem_req_o),
    .mem_addr_o   (mem_addr_o),
    .mem_rvalid_i (mem_rvalid_i),
    .mem_rdata_i  (mem_rdata_i)
  );

  fetch_predecode i_fetch_predecode (
    .inst_i  (hit_inst),
    .class_o (inst_class)
  );

endmodule

//--- design/fetch_ctrl.sv
`timescale 1ns/10ps

module fetch_ctrl #(
  parameter int                addr_w   = 32,
  parameter logic [addr_w-1:0] reset_pc = 'h1000
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   redirect_i,
  input  logic [addr_w-1:0]      redirect_pc_i,
  input  logic                   hit_i,
  input  logic [31:0]            hit_inst_i,
  input  fetch_pkg::inst_class_e class_i,
  output logic [addr_w-1:0]      fetch_pc_o,
  output logic                   fetch_en_o,
  output logic                   invalidate_o,
  output logic [31:0]            inst_o,
  output logic [addr_w-1:0]      pc_o,
  output logic                   valid_o,
  input  logic                   ready_i
);
  import fetch_pkg::*;

  localparam logic [addr_w-1:0] pc_step = addr_w'(1) << word_off_w;

  logic [addr_w-1:0] pc_q;
  logic              stopped_q; // waiting for the back end to redirect.
  logic              transfer;
  logic [addr_w-1:0] redirect_word;

  assign fetch_pc_o = pc_q;
  assign fetch_en_o = !stopped_q;

  // hit data goes straight to decode, so a hit costs no extra cycle.
  assign valid_o = hit_i && fetch_en_o;
  assign inst_o  = hit_inst_i;
  assign pc_o    = pc_q;

  assign transfer     = valid_o && ready_i;
  assign invalidate_o = transfer && (class_i == class_fence);

  assign redirect_word = {redirect_pc_i[addr_w-1:word_off_w], {word_off_w{1'b0}}};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q      <= reset_pc;
      stopped_q <= 1'b0;
    end
    else if (stopped_q)
    begin
      if (redirect_i)
      begin
        pc_q      <= redirect_word;
        stopped_q <= 1'b0;
      end
    end
    else if (transfer)
    begin
      case (class_i)
        class_ctrl:
        begin
          stopped_q <= 1'b1; // target is unknown here.
        end
        default:
        begin
          pc_q <= pc_q + pc_step; // seq and fence.i fall through.
        end
      endcase
    end
  end

endmodule

//--- design/icache.sv
`timescale 1ns/10ps

module icache #(
  parameter int addr_w  = 32,
  parameter int index_w = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [addr_w-1:0] fetch_pc_i,
  input  logic              fetch_en_i,
  input  logic              invalidate_i,
  output logic              hit_o,
  output logic [31:0]       inst_o,
  output logic              mem_req_o,
  output logic [addr_w-1:0] mem_addr_o,
  input  logic              mem_rvalid_i,
  input  logic [31:0]       mem_rdata_i
);
  import fetch_pkg::*;

  localparam int lines    = 1 << index_w;
  localparam int line_lsb = word_off_w + 1; // one word-select bit per line.
  localparam int tag_lsb  = line_lsb + index_w;
  localparam int tag_w    = addr_w - tag_lsb;
  localparam int line_w   = addr_w - line_lsb;

  logic [31:0]      data_mem [lines][2];
  logic [tag_w-1:0] tag_mem [lines];
  logic [lines-1:0] valid_q;

  refill_state_e state_q;
  logic [line_w-1:0] miss_line_q; // tag and index of the line being filled.

  logic [tag_w-1:0]   pc_tag;
  logic [index_w-1:0] pc_index;
  logic               pc_word;
  logic [tag_w-1:0]   fill_tag;
  logic [index_w-1:0] fill_index;
  logic               beat_hi;
  logic               miss;
  logic               fill_lo;
  logic               fill_hi;

  assign pc_tag     = fetch_pc_i[addr_w-1:tag_lsb];
  assign pc_index   = fetch_pc_i[tag_lsb-1:line_lsb];
  assign pc_word    = fetch_pc_i[word_off_w];
  assign fill_tag   = miss_line_q[line_w-1:index_w];
  assign fill_index = miss_line_q[index_w-1:0];

  // lookup is only trusted while no refill is running.
  assign hit_o  = (state_q == cache_idle) && valid_q[pc_index] &&
                  (tag_mem[pc_index] == pc_tag);
  assign inst_o = data_mem[pc_index][pc_word];

  assign miss    = (state_q == cache_idle) && fetch_en_i && !hit_o;
  assign fill_lo = (state_q == wait_lo) && mem_rvalid_i;
  assign fill_hi = (state_q == wait_hi) && mem_rvalid_i;

  // request strobes last a single cycle each.
  assign beat_hi    = (state_q == req_hi);
  assign mem_req_o  = (state_q == req_lo) || beat_hi;
  assign mem_addr_o = {miss_line_q, beat_hi, {word_off_w{1'b0}}};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= cache_idle;
    end
    else
    begin
      case (state_q)
        cache_idle:
        begin
          if (miss)
            state_q <= req_lo;
        end
        req_lo:
        begin
          state_q <= wait_lo;
        end
        wait_lo:
        begin
          if (mem_rvalid_i)
            state_q <= req_hi;
        end
        req_hi:
        begin
          state_q <= wait_hi;
        end
        wait_hi:
        begin
          if (mem_rvalid_i)
            state_q <= cache_idle; // line hits on the next cycle.
        end
        default:
        begin
          state_q <= cache_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (invalidate_i)
    begin
      valid_q <= '0; // fence.i drops every line.
    end
    else if (fill_hi)
    begin
      valid_q[fill_index] <= 1'b1;
    end
  end

  // line address is latched while idle and held through the refill.
  always_ff @(posedge clk)
  begin
    if (state_q == cache_idle)
      miss_line_q <= fetch_pc_i[addr_w-1:line_lsb];
  end

  always_ff @(posedge clk)
  begin
    if (fill_lo)
      data_mem[fill_index][0] <= mem_rdata_i;
    if (fill_hi)
    begin
      data_mem[fill_index][1] <= mem_rdata_i;
      tag_mem[fill_index]     <= fill_tag;
    end
  end

endmodule

//--- design/fetch_predecode.sv
`timescale 1ns/10ps

module fetch_predecode (
  input  logic [31:0]            inst_i,
  output fetch_pkg::inst_class_e class_o
);
  import fetch_pkg::*;

  opcode_e opcode;

  always_comb
  begin
    case (inst_i[6:0])
      op_jal:      opcode = op_jal;
      op_jalr:     opcode = op_jalr;
      op_branch:   opcode = op_branch;
      op_system:   opcode = op_system;
      op_misc_mem: opcode = op_misc_mem;
      default:     opcode = op_other;
    endcase
  end

  // plain fence shares misc_mem and stays sequential.
  always_comb
  begin
    if (inst_i == fence_i_inst)
      class_o = class_fence;
    else
    begin
      case (opcode)
        op_jal, op_jalr, op_branch, op_system: class_o = class_ctrl;
        default:                               class_o = class_seq;
      endcase
    end
  end

endmodule

//--- design/fetch_pkg.sv
package fetch_pkg;

  // major opcodes seen by the predecoder.
  typedef enum logic [6:0] {
    op_other    = 7'b0000000,
    op_misc_mem = 7'b0001111,
    op_branch   = 7'b1100011,
    op_jalr     = 7'b1100111,
    op_jal      = 7'b1101111,
    op_system   = 7'b1110011
  } opcode_e;

  // two-beat line refill.
  typedef enum logic [2:0] {
    cache_idle,
    req_lo,
    wait_lo,
    req_hi,
    wait_hi
  } refill_state_e;

  typedef enum logic [1:0] {
    class_seq,
    class_ctrl,
    class_fence
  } inst_class_e;

  // fence.i with all-zero rd, rs1 and imm.
  localparam logic [31:0] fence_i_inst = 32'h0000_100f;

  localparam int word_off_w = 2; // byte offset within a word.

endpackage
